// ==== alu_ops_pkg.sv ====
`default_nettype none

package alu_ops_pkg;

    // ------------------------------------------------------------
    // widths
    // ------------------------------------------------------------
    localparam int DATA_W     = 32;
    localparam int FIELD_W    = 8;
    localparam int NUM_FIELDS = 4;
    localparam int OFFSET_W   = 12;
    localparam int ID_W       = 4;

    // ------------------------------------------------------------
    // operations
    // ------------------------------------------------------------
    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_MAX    = 3'd5,
        ALU_MIN    = 3'd6,
        ALU_PASS_B = 3'd7
    } alu_op_t;

    // word 1 of a sequence
    typedef struct packed {
        logic [DATA_W-2*ID_W-NUM_FIELDS-1:0] rsvd;
        logic [ID_W-1:0]                     id_engine;
        logic [ID_W-1:0]                     id_module;
        logic [NUM_FIELDS-1:0]               alu_mask;
    } cfg_mask_view_t;

    // word 4 of a sequence
    typedef struct packed {
        logic [DATA_W-3*ID_W-1:0] rsvd;
        logic [ID_W-1:0]          id_lane;
        logic [ID_W-1:0]          id_bundle;
        logic [ID_W-1:0]          id_cu;
    } cfg_route_view_t;

    typedef union packed {
        cfg_mask_view_t  mask;
        cfg_route_view_t route;
        logic [DATA_W-1:0] raw;
    } cfg_word_u;

    // one decoded configuration, as stored in the FIFO
    typedef struct packed {
        alu_op_t               op;
        logic [NUM_FIELDS-1:0] alu_mask;
        logic [NUM_FIELDS-1:0] const_mask;
        logic [FIELD_W-1:0]    const_value;
        logic [ID_W-1:0]       id_cu;
        logic [ID_W-1:0]       id_bundle;
        logic [ID_W-1:0]       id_lane;
    } alu_cfg_t;

    localparam int CFG_W = $bits(alu_cfg_t);

endpackage

`default_nettype wire

// ==== alu_ops_axil_write.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_ops_axil_write
    import alu_ops_pkg::*;
(
    input  logic                ap_clk,
    input  logic                areset_alu_ops_generator,
    input  logic                awvalid,
    output logic                awready,
    input  logic [13:0]         awaddr,
    input  logic                wvalid,
    output logic                wready,
    input  logic [DATA_W-1:0]   wdata,
    output logic                bvalid,
    input  logic                bready,
    output logic [1:0]          bresp,
    output logic                word_valid,
    output logic [OFFSET_W-1:0] word_offset,
    output logic [DATA_W-1:0]   word_data
);

typedef enum logic [1:0] {
    ST_IDLE,
    ST_ACCEPT,
    ST_RESP
} state_t;

state_t state;

// writes never fail
assign bresp = 2'b00;

// ------------------------------------------------------------
// handshake FSM
// ------------------------------------------------------------
always_ff @(posedge ap_clk) begin
    if (areset_alu_ops_generator) begin
        state      <= ST_IDLE;
        awready    <= 1'b0;
        wready     <= 1'b0;
        bvalid     <= 1'b0;
        word_valid <= 1'b0;
    end else begin
        word_valid <= 1'b0;
        case (state)
            ST_IDLE: begin
                // wait for address and data together
                if (awvalid && wvalid) begin
                    awready <= 1'b1;
                    wready  <= 1'b1;
                    state   <= ST_ACCEPT;
                end
            end
            ST_ACCEPT: begin
                awready    <= 1'b0;
                wready     <= 1'b0;
                bvalid     <= 1'b1;
                word_valid <= 1'b1;
                state      <= ST_RESP;
            end
            ST_RESP: begin
                if (bready) begin
                    bvalid <= 1'b0;
                    state  <= ST_IDLE;
                end
            end
            default: state <= ST_IDLE;
        endcase
    end
end

// byte address to word offset
always_ff @(posedge ap_clk) begin
    if (state == ST_ACCEPT) begin
        word_offset <= awaddr[OFFSET_W+1:2];
        word_data   <= wdata;
    end
end

endmodule

`default_nettype wire

// ==== alu_ops_configure_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_ops_configure_memory
    import alu_ops_pkg::*;
#(
    parameter int ENGINE_SEQ_WIDTH = 8,
    parameter int ID_RELATIVE      = 1
) (
    input  logic                ap_clk,
    input  logic                areset_alu_ops_generator,
    input  logic                word_valid,
    input  logic [OFFSET_W-1:0] word_offset,
    input  logic [DATA_W-1:0]   word_data,
    output logic                cfg_push,
    output alu_cfg_t            cfg_data,
    output logic                busy
);

// window of word offsets owned by this engine
localparam int SEQ_MIN = ID_RELATIVE * ENGINE_SEQ_WIDTH;
localparam int SEQ_MAX = SEQ_MIN + ENGINE_SEQ_WIDTH;

logic                        in_valid;
logic [OFFSET_W-1:0]         in_offset;
logic [DATA_W-1:0]           in_data;
logic                        filt_valid;
logic                        dec_valid;
cfg_word_u                   dec_word;
logic [ENGINE_SEQ_WIDTH-1:0] seq;

// ------------------------------------------------------------
// input register and window filter
// ------------------------------------------------------------
always_ff @(posedge ap_clk) begin
    if (areset_alu_ops_generator) begin
        in_valid <= 1'b0;
    end else begin
        in_valid <= word_valid;
    end
end

always_ff @(posedge ap_clk) begin
    in_offset <= word_offset;
    in_data   <= word_data;
end

assign filt_valid = in_valid
                  && (int'(in_offset) >= SEQ_MIN)
                  && (int'(in_offset) < SEQ_MAX);

// ------------------------------------------------------------
// sequence tracker
// ------------------------------------------------------------
always_ff @(posedge ap_clk) begin
    if (areset_alu_ops_generator) begin
        seq       <= '0;
        dec_valid <= 1'b0;
        cfg_push  <= 1'b0;
    end else begin
        dec_valid <= filt_valid;
        // top bit lasts one cycle, so one push per sequence
        cfg_push  <= seq[ENGINE_SEQ_WIDTH-1];
        if (seq[ENGINE_SEQ_WIDTH-1]) begin
            seq <= '0;
        end else if (filt_valid) begin
            if ((int'(in_offset) == SEQ_MIN) && (seq == '0)) begin
                seq <= ENGINE_SEQ_WIDTH'(1);
            end else begin
                // a stray word with no sequence shifts zero and stays idle
                seq <= seq << 1;
            end
        end
    end
end

always_ff @(posedge ap_clk) begin
    dec_word <= in_data;
end

// ------------------------------------------------------------
// field decoder, one word per sequence position
// ------------------------------------------------------------
always_ff @(posedge ap_clk) begin
    if (dec_valid) begin
        case (seq)
            ENGINE_SEQ_WIDTH'(1 << 0): begin
                cfg_data.op <= alu_op_t'(dec_word.raw[2:0]);
            end
            ENGINE_SEQ_WIDTH'(1 << 1): begin
                cfg_data.alu_mask <= dec_word.mask.alu_mask;
            end
            ENGINE_SEQ_WIDTH'(1 << 2): begin
                cfg_data.const_mask <= dec_word.raw[NUM_FIELDS-1:0];
            end
            ENGINE_SEQ_WIDTH'(1 << 3): begin
                cfg_data.const_value <= dec_word.raw[FIELD_W-1:0];
            end
            ENGINE_SEQ_WIDTH'(1 << 4): begin
                cfg_data.id_cu     <= dec_word.route.id_cu;
                cfg_data.id_bundle <= dec_word.route.id_bundle;
                cfg_data.id_lane   <= dec_word.route.id_lane;
            end
            // positions 5 and up carry nothing
            default: begin
            end
        endcase
    end
end

assign busy = (|seq) | cfg_push;

endmodule

`default_nettype wire

// ==== alu_ops_config_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_ops_config_fifo
    import alu_ops_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic     ap_clk,
    input  logic     areset_alu_ops_generator,
    input  logic     wr_en,
    input  alu_cfg_t din,
    input  logic     rd_en,
    output alu_cfg_t dout,
    output logic     full,
    output logic     empty,
    output logic     valid
);

localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

logic [CFG_W-1:0] mem [FIFO_DEPTH];
logic [PTR_W-1:0] wr_ptr;
logic [PTR_W-1:0] rd_ptr;
logic [CNT_W-1:0] count;
logic             do_wr;
logic             do_rd;

assign full  = (count == CNT_W'(FIFO_DEPTH));
assign empty = (count == '0);
// push into a full buffer is lost
assign do_wr = wr_en & ~full;
assign do_rd = rd_en & ~empty;

always_ff @(posedge ap_clk) begin
    if (areset_alu_ops_generator) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
        valid  <= 1'b0;
    end else begin
        valid <= do_rd;
        if (do_wr) begin
            wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        end
        if (do_rd) begin
            rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        end
        case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
        endcase
    end
end

// storage and registered read port
always_ff @(posedge ap_clk) begin
    if (do_wr) begin
        mem[wr_ptr] <= din;
    end
    if (do_rd) begin
        dout <= alu_cfg_t'(mem[rd_ptr]);
    end
end

endmodule

`default_nettype wire

// ==== alu_ops_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_ops_engine
    import alu_ops_pkg::*;
(
    input  logic              ap_clk,
    input  logic              areset_alu_ops_generator,
    input  logic              fifo_empty,
    input  logic              fifo_valid,
    input  alu_cfg_t          fifo_dout,
    output logic              fifo_rd_en,
    output logic              read_busy,
    input  logic              operand_valid,
    output logic              operand_ready,
    input  logic [DATA_W-1:0] operand_a,
    input  logic [DATA_W-1:0] operand_b,
    output logic              result_valid,
    input  logic              result_ready,
    output logic [DATA_W-1:0] result_data,
    output logic [ID_W-1:0]   result_cu,
    output logic [ID_W-1:0]   result_bundle,
    output logic [ID_W-1:0]   result_lane
);

logic              cfg_loaded;
alu_cfg_t          active_cfg;
logic              s1_valid;
logic [DATA_W-1:0] s1_a;
logic [DATA_W-1:0] s1_b;
alu_cfg_t          s1_cfg;
logic              s2_en;
logic              s1_take;
logic [DATA_W-1:0] b_sel;
logic [DATA_W-1:0] alu_out;

function automatic logic [FIELD_W-1:0] alu_field(
    input alu_op_t            op,
    input logic [FIELD_W-1:0] a,
    input logic [FIELD_W-1:0] b
);
    case (op)
        ALU_ADD: return a + b;
        ALU_SUB: return a - b;
        ALU_AND: return a & b;
        ALU_OR:  return a | b;
        ALU_XOR: return a ^ b;
        ALU_MAX: return (a > b) ? a : b;
        ALU_MIN: return (a < b) ? a : b;
        default: return b;
    endcase
endfunction

// ------------------------------------------------------------
// configuration load
// ------------------------------------------------------------
assign fifo_rd_en = ~fifo_empty & ~read_busy;

always_ff @(posedge ap_clk) begin
    if (areset_alu_ops_generator) begin
        read_busy  <= 1'b0;
        cfg_loaded <= 1'b0;
    end else begin
        read_busy <= fifo_rd_en | (read_busy & ~fifo_valid);
        if (fifo_valid) begin
            cfg_loaded <= 1'b1;
        end
    end
end

always_ff @(posedge ap_clk) begin
    if (fifo_valid) begin
        active_cfg <= fifo_dout;
    end
end

// ------------------------------------------------------------
// two-stage pipeline
// ------------------------------------------------------------
assign s2_en         = ~result_valid | result_ready;
assign operand_ready = cfg_loaded & ~fifo_rd_en & ~read_busy & (~s1_valid | s2_en);
assign s1_take       = operand_valid & operand_ready;

always_comb begin
    for (int i = 0; i < NUM_FIELDS; i++) begin
        b_sel[i*FIELD_W +: FIELD_W] = active_cfg.const_mask[i] ? active_cfg.const_value
                                                                : operand_b[i*FIELD_W +: FIELD_W];
        // unmasked fields pass A through
        alu_out[i*FIELD_W +: FIELD_W] = s1_cfg.alu_mask[i]
            ? alu_field(s1_cfg.op, s1_a[i*FIELD_W +: FIELD_W], s1_b[i*FIELD_W +: FIELD_W])
            : s1_a[i*FIELD_W +: FIELD_W];
    end
end

always_ff @(posedge ap_clk) begin
    if (areset_alu_ops_generator) begin
        s1_valid     <= 1'b0;
        result_valid <= 1'b0;
    end else begin
        if (s2_en) begin
            result_valid <= s1_valid;
        end
        if (s1_take) begin
            s1_valid <= 1'b1;
        end else if (s2_en) begin
            s1_valid <= 1'b0;
        end
    end
end

// each packet carries its own config, so a reload cannot touch packets in flight
always_ff @(posedge ap_clk) begin
    if (s1_take) begin
        s1_a   <= operand_a;
        s1_b   <= b_sel;
        s1_cfg <= active_cfg;
    end
    if (s2_en && s1_valid) begin
        result_data   <= alu_out;
        result_cu     <= s1_cfg.id_cu;
        result_bundle <= s1_cfg.id_bundle;
        result_lane   <= s1_cfg.id_lane;
    end
end

endmodule

`default_nettype wire

// ==== alu_ops_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_ops_top
    import alu_ops_pkg::*;
#(
    parameter int ENGINE_SEQ_WIDTH = 8,
    parameter int ID_RELATIVE      = 1,
    parameter int FIFO_DEPTH       = 4
) (
    input  logic              ap_clk,
    input  logic              areset_alu_ops_generator,
    input  logic              awvalid,
    output logic              awready,
    input  logic [13:0]       awaddr,
    input  logic              wvalid,
    output logic              wready,
    input  logic [DATA_W-1:0] wdata,
    output logic              bvalid,
    input  logic              bready,
    output logic [1:0]        bresp,
    input  logic              operand_valid,
    output logic              operand_ready,
    input  logic [DATA_W-1:0] operand_a,
    input  logic [DATA_W-1:0] operand_b,
    output logic              result_valid,
    input  logic              result_ready,
    output logic [DATA_W-1:0] result_data,
    output logic [ID_W-1:0]   result_cu,
    output logic [ID_W-1:0]   result_bundle,
    output logic [ID_W-1:0]   result_lane,
    output logic              cfg_pending
);

logic                word_valid;
logic [OFFSET_W-1:0] word_offset;
logic [DATA_W-1:0]   word_data;
logic                cfg_push;
alu_cfg_t            cfg_data;
logic                cfg_busy;
logic                fifo_rd_en;
logic                fifo_empty;
logic                fifo_full;
logic                fifo_valid;
alu_cfg_t            fifo_dout;
logic                read_busy;

// ------------------------------------------------------------
// host side producer
// ------------------------------------------------------------
alu_ops_axil_write u_axil_write (
    .ap_clk                   (ap_clk),
    .areset_alu_ops_generator (areset_alu_ops_generator),
    .awvalid                  (awvalid),
    .awready                  (awready),
    .awaddr                   (awaddr),
    .wvalid                   (wvalid),
    .wready                   (wready),
    .wdata                    (wdata),
    .bvalid                   (bvalid),
    .bready                   (bready),
    .bresp                    (bresp),
    .word_valid               (word_valid),
    .word_offset              (word_offset),
    .word_data                (word_data)
);

alu_ops_configure_memory #(
    .ENGINE_SEQ_WIDTH (ENGINE_SEQ_WIDTH),
    .ID_RELATIVE      (ID_RELATIVE)
) u_configure_memory (
    .ap_clk                   (ap_clk),
    .areset_alu_ops_generator (areset_alu_ops_generator),
    .word_valid               (word_valid),
    .word_offset              (word_offset),
    .word_data                (word_data),
    .cfg_push                 (cfg_push),
    .cfg_data                 (cfg_data),
    .busy                     (cfg_busy)
);

// ------------------------------------------------------------
// buffer and consumer
// ------------------------------------------------------------
alu_ops_config_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
) u_config_fifo (
    .ap_clk                   (ap_clk),
    .areset_alu_ops_generator (areset_alu_ops_generator),
    .wr_en                    (cfg_push),
    .din                      (cfg_data),
    .rd_en                    (fifo_rd_en),
    .dout                     (fifo_dout),
    .full                     (fifo_full),
    .empty                    (fifo_empty),
    .valid                    (fifo_valid)
);

alu_ops_engine u_engine (
    .ap_clk                   (ap_clk),
    .areset_alu_ops_generator (areset_alu_ops_generator),
    .fifo_empty               (fifo_empty),
    .fifo_valid               (fifo_valid),
    .fifo_dout                (fifo_dout),
    .fifo_rd_en               (fifo_rd_en),
    .read_busy                (read_busy),
    .operand_valid            (operand_valid),
    .operand_ready            (operand_ready),
    .operand_a                (operand_a),
    .operand_b                (operand_b),
    .result_valid             (result_valid),
    .result_ready             (result_ready),
    .result_data              (result_data),
    .result_cu                (result_cu),
    .result_bundle            (result_bundle),
    .result_lane              (result_lane)
);

// low once every written configuration sits in the engine
assign cfg_pending = cfg_busy | ~fifo_empty | read_busy;

endmodule

`default_nettype wire

// ==== alu_ops_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_ops_chk
    import alu_ops_pkg::*;
(
    input logic              ap_clk,
    input logic              areset_alu_ops_generator,
    input logic              awvalid,
    input logic              awready,
    input logic [13:0]       awaddr,
    input logic              wvalid,
    input logic              wready,
    input logic [DATA_W-1:0] wdata,
    input logic              cfg_push,
    input logic              fifo_full,
    input logic              result_valid,
    input logic              result_ready,
    input logic [DATA_W-1:0] result_data
);

// ------------------------------------------------------------
// host write channel
// ------------------------------------------------------------
awaddr_hold: assert property (@(posedge ap_clk) disable iff (areset_alu_ops_generator)
    awvalid && !awready |=> awvalid && $stable(awaddr))
    else $error("awaddr or awvalid changed while the write was stalled");

wdata_hold: assert property (@(posedge ap_clk) disable iff (areset_alu_ops_generator)
    wvalid && !wready |=> wvalid && $stable(wdata))
    else $error("wdata or wvalid changed while the write was stalled");

// a config pushed into a full buffer would be lost
no_push_full: assert property (@(posedge ap_clk) disable iff (areset_alu_ops_generator)
    cfg_push |-> !fifo_full)
    else $error("configuration pushed into a full FIFO");

// ------------------------------------------------------------
// result stream
// ------------------------------------------------------------
result_hold: assert property (@(posedge ap_clk) disable iff (areset_alu_ops_generator)
    result_valid && !result_ready |=> result_valid && $stable(result_data))
    else $error("result changed while result_ready was low");

endmodule

bind alu_ops_top alu_ops_chk alu_ops_chk_i (
    .ap_clk                   (ap_clk),
    .areset_alu_ops_generator (areset_alu_ops_generator),
    .awvalid                  (awvalid),
    .awready                  (awready),
    .awaddr                   (awaddr),
    .wvalid                   (wvalid),
    .wready                   (wready),
    .wdata                    (wdata),
    .cfg_push                 (cfg_push),
    .fifo_full                (fifo_full),
    .result_valid             (result_valid),
    .result_ready             (result_ready),
    .result_data              (result_data)
);

`default_nettype wire

// ==== alu_ops_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_ops_tb
    import alu_ops_pkg::*;
();

localparam int SEQ_WIDTH = 8;
localparam int ID_REL    = 1;
localparam int SEQ_MIN   = ID_REL * SEQ_WIDTH;
localparam int TIMEOUT   = 1000;

logic                ap_clk;
logic                areset_alu_ops_generator;
logic                awvalid;
logic                awready;
logic [13:0]         awaddr;
logic                wvalid;
logic                wready;
logic [DATA_W-1:0]   wdata;
logic                bvalid;
logic                bready;
logic [1:0]          bresp;
logic                operand_valid;
logic                operand_ready;
logic [DATA_W-1:0]   operand_a;
logic [DATA_W-1:0]   operand_b;
logic                result_valid;
logic                result_ready;
logic [DATA_W-1:0]   result_data;
logic [ID_W-1:0]     result_cu;
logic [ID_W-1:0]     result_bundle;
logic [ID_W-1:0]     result_lane;
logic                cfg_pending;

int                  error_count;
int                  check_count;
bit                  random_ready;
alu_cfg_t            model_cfg;
alu_cfg_t            cfg_a;
alu_cfg_t            cfg_b;
// lane, bundle, cu and data of each packet still in flight
logic [3*ID_W+DATA_W-1:0] expect_q [$];

alu_ops_top #(
    .ENGINE_SEQ_WIDTH (SEQ_WIDTH),
    .ID_RELATIVE      (ID_REL),
    .FIFO_DEPTH       (4)
) alu_ops_top_i (
    .ap_clk                   (ap_clk),
    .areset_alu_ops_generator (areset_alu_ops_generator),
    .awvalid                  (awvalid),
    .awready                  (awready),
    .awaddr                   (awaddr),
    .wvalid                   (wvalid),
    .wready                   (wready),
    .wdata                    (wdata),
    .bvalid                   (bvalid),
    .bready                   (bready),
    .bresp                    (bresp),
    .operand_valid            (operand_valid),
    .operand_ready            (operand_ready),
    .operand_a                (operand_a),
    .operand_b                (operand_b),
    .result_valid             (result_valid),
    .result_ready             (result_ready),
    .result_data              (result_data),
    .result_cu                (result_cu),
    .result_bundle            (result_bundle),
    .result_lane              (result_lane),
    .cfg_pending              (cfg_pending)
);

always #4 ap_clk = ~ap_clk;

// ------------------------------------------------------------
// reference model and helpers
// ------------------------------------------------------------
function automatic logic [DATA_W-1:0] alu_ref(
    input alu_cfg_t          cfg,
    input logic [DATA_W-1:0] a,
    input logic [DATA_W-1:0] b
);
    logic [7:0]        fa;
    logic [7:0]        fb;
    logic [7:0]        fr;
    logic [DATA_W-1:0] res;
    for (int i = 0; i < 4; i++) begin
        fa = a[8*i +: 8];
        // constant replaces B where selected
        fb = cfg.const_mask[i] ? cfg.const_value : b[8*i +: 8];
        case (cfg.op)
            ALU_ADD: fr = fa + fb;
            ALU_SUB: fr = fa - fb;
            ALU_AND: fr = fa & fb;
            ALU_OR:  fr = fa | fb;
            ALU_XOR: fr = fa ^ fb;
            ALU_MAX: fr = (fa >= fb) ? fa : fb;
            ALU_MIN: fr = (fa <= fb) ? fa : fb;
            default: fr = fb;
        endcase
        res[8*i +: 8] = cfg.alu_mask[i] ? fr : fa;
    end
    return res;
endfunction

function automatic alu_cfg_t random_cfg(input alu_op_t op);
    alu_cfg_t cfg;
    cfg.op          = op;
    cfg.alu_mask    = 4'($urandom());
    cfg.const_mask  = 4'($urandom());
    cfg.const_value = 8'($urandom());
    cfg.id_cu       = 4'($urandom());
    cfg.id_bundle   = 4'($urandom());
    cfg.id_lane     = 4'($urandom());
    return cfg;
endfunction

task automatic compare_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    assert (got == exp) else begin
        $display("[FAIL] %s: got %h, expected %h", name, got, exp);
        error_count++;
    end
endtask

task automatic report_timeout(input string what);
    $display("timed out after %0d cycles waiting for %s", TIMEOUT, what);
    error_count++;
endtask

task automatic step();
    @(posedge ap_clk);
    #1;
endtask

task automatic axil_write(input logic [OFFSET_W-1:0] offset, input logic [DATA_W-1:0] data);
    int waited;
    awaddr  = {offset, 2'b00};
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    waited  = 0;
    @(negedge ap_clk);
    while (!(awready && wready) && waited < TIMEOUT) begin
        @(negedge ap_clk);
        waited++;
    end
    if (!(awready && wready)) begin
        report_timeout("awready and wready");
        awvalid = 1'b0;
        wvalid  = 1'b0;
        return;
    end
    step();
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    waited  = 0;
    @(negedge ap_clk);
    while (!bvalid && waited < TIMEOUT) begin
        @(negedge ap_clk);
        waited++;
    end
    if (!bvalid) begin
        report_timeout("bvalid");
    end else begin
        compare_value("bresp", 32'(bresp), 32'h0);
    end
    step();
    bready = 1'b0;
endtask

// one full sequence, junk in the bits the decoder ignores
// strays go outside the window, between word 0 and word 1
task automatic write_config(input alu_cfg_t cfg, input bit with_strays);
    logic [DATA_W-1:0] words [SEQ_WIDTH];
    for (int i = 0; i < SEQ_WIDTH; i++) begin
        words[i] = $urandom();
    end
    words[0][2:0]  = cfg.op;
    words[1][3:0]  = cfg.alu_mask;
    words[2][3:0]  = cfg.const_mask;
    words[3][7:0]  = cfg.const_value;
    words[4][11:0] = {cfg.id_lane, cfg.id_bundle, cfg.id_cu};
    for (int i = 0; i < SEQ_WIDTH; i++) begin
        axil_write(12'(SEQ_MIN + i), words[i]);
        if (i == 0 && with_strays) begin
            axil_write(12'(SEQ_MIN - 1), $urandom());
            axil_write(12'(SEQ_MIN + SEQ_WIDTH), $urandom());
            axil_write(12'h0, $urandom());
        end
    end
endtask

task automatic wait_cfg_applied();
    int waited;
    waited = 0;
    while (cfg_pending && waited < TIMEOUT) begin
        step();
        waited++;
    end
    if (cfg_pending) begin
        report_timeout("cfg_pending to fall");
    end
endtask

task automatic send_operands(input int count);
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    int                waited;
    for (int n = 0; n < count; n++) begin
        a             = $urandom();
        b             = $urandom();
        operand_a     = a;
        operand_b     = b;
        operand_valid = 1'b1;
        waited        = 0;
        @(negedge ap_clk);
        while (!operand_ready && waited < TIMEOUT) begin
            @(negedge ap_clk);
            waited++;
        end
        if (!operand_ready) begin
            report_timeout("operand_ready");
            operand_valid = 1'b0;
            return;
        end
        expect_q.push_back({model_cfg.id_lane, model_cfg.id_bundle, model_cfg.id_cu,
                            alu_ref(model_cfg, a, b)});
        step();
    end
    operand_valid = 1'b0;
endtask

task automatic drain_results();
    int waited;
    waited = 0;
    while (expect_q.size() != 0 && waited < TIMEOUT) begin
        step();
        waited++;
    end
    if (expect_q.size() != 0) begin
        report_timeout("outstanding results");
    end
endtask

// ------------------------------------------------------------
// result side
// ------------------------------------------------------------
always @(posedge ap_clk) begin
    #1;
    result_ready = random_ready ? 1'($urandom()) : 1'b1;
end

always @(negedge ap_clk) begin : compare_results
    logic [3*ID_W+DATA_W-1:0] expected;
    if (result_valid && result_ready) begin
        if (expect_q.size() == 0) begin
            $display("result delivered with no packet outstanding");
            error_count++;
        end else begin
            expected = expect_q.pop_front();
            compare_value("result_data", result_data, expected[31:0]);
            compare_value("result_cu", 32'(result_cu), 32'(expected[35:32]));
            compare_value("result_bundle", 32'(result_bundle), 32'(expected[39:36]));
            compare_value("result_lane", 32'(result_lane), 32'(expected[43:40]));
        end
    end
end

// ------------------------------------------------------------
// main sequence
// ------------------------------------------------------------
initial begin
    void'($urandom(32'he9ab_4274));
    ap_clk                   = 1'b0;
    areset_alu_ops_generator = 1'b1;
    awvalid                  = 1'b0;
    awaddr                   = '0;
    wvalid                   = 1'b0;
    wdata                    = '0;
    bready                   = 1'b0;
    operand_valid            = 1'b0;
    operand_a                = '0;
    operand_b                = '0;
    result_ready             = 1'b1;
    random_ready             = 1'b0;
    error_count              = 0;
    check_count              = 0;
    model_cfg                = '0;
    repeat (8) @(posedge ap_clk);
    #1;
    areset_alu_ops_generator = 1'b0;
    step();

    compare_value("awready", 32'(awready), 32'h0);
    compare_value("wready", 32'(wready), 32'h0);
    compare_value("bvalid", 32'(bvalid), 32'h0);
    compare_value("operand_ready", 32'(operand_ready), 32'h0);
    compare_value("result_valid", 32'(result_valid), 32'h0);
    compare_value("cfg_pending", 32'(cfg_pending), 32'h0);

    // first configuration opens the operand path
    cfg_a = random_cfg(ALU_ADD);
    write_config(cfg_a, 1'b0);
    wait_cfg_applied();
    model_cfg = cfg_a;
    compare_value("operand_ready", 32'(operand_ready), 32'h1);
    send_operands(20);
    drain_results();

    // every operation once
    for (int k = 0; k < 8; k++) begin
        cfg_a = random_cfg(alu_op_t'(3'(k)));
        write_config(cfg_a, 1'b0);
        wait_cfg_applied();
        model_cfg = cfg_a;
        send_operands(16);
        drain_results();
    end

    // stray words must leave the active config alone
    write_config(model_cfg, 1'b1);
    for (int i = 1; i < SEQ_WIDTH; i++) begin
        axil_write(12'(SEQ_MIN + i), $urandom());
    end
    wait_cfg_applied();
    send_operands(16);
    drain_results();

    // output stalls
    random_ready = 1'b1;
    send_operands(64);
    drain_results();

    // two sequences back to back, second one wins
    cfg_a = random_cfg(alu_op_t'(3'($urandom())));
    cfg_b = random_cfg(alu_op_t'(3'($urandom())));
    write_config(cfg_a, 1'b0);
    write_config(cfg_b, 1'b0);
    wait_cfg_applied();
    model_cfg = cfg_b;
    send_operands(24);
    drain_results();
    random_ready = 1'b0;
    step();

    $display("checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
        $display("Everything OK");
    end else begin
        $display("Something failed");
    end
    $finish;
end

endmodule

`default_nettype wire

// ==== alu_ops.f ====
alu_ops_pkg.sv
alu_ops_axil_write.sv
alu_ops_configure_memory.sv
alu_ops_config_fifo.sv
alu_ops_engine.sv
alu_ops_top.sv
alu_ops_chk.sv
alu_ops_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module alu_ops_tb -f alu_ops.f \
    && ./obj_dir/Valu_ops_tb > sim.log 2>&1 \
    || echo "Something failed" >> sim.log
cat sim.log
grep -q "Something failed" sim.log && exit 1 || exit 0
